//--- irf_top.f
source/irf_pkg.sv
source/irf_window_ctl.sv
source/irf_wr_path.sv
source/irf_cell.sv
source/irf_bank.sv
source/irf_rd_path.sv
source/irf_top.sv
test/irf_clk_gen.sv
test/irf_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the irf testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f irf_top.f \
  --top-module irf_tb \
  -o irf_sim

# a simulator that exits with an error counts as a failed run
if ! ./obj_dir/irf_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulator exited with an error"
  exit 1
fi
cat sim.log

if grep -q "Something failed" sim.log; then
  exit 1
fi

//--- test/irf_tb.sv
// ==========================================================================
// irf testbench
// directed and random requests against the windowed register file
// with every read and trap compared against a reference model
// ==========================================================================

`timescale 1ns/10ps

module irf_tb;

  logic                          clk;
  logic                          reset_l;
  irf_pkg::irf_req_t             req;
  logic                          rd_en;
  logic                          rd_thread;
  logic [irf_pkg::REG_IDX_W-1:0] rd_idx;
  irf_pkg::irf_rd_t              rd;
  irf_pkg::irf_trap_t            trap;

  // reference model with registers, window slots and counts per thread
  logic [irf_pkg::WORD_W-1:0] m_regs       [2][8];
  logic [irf_pkg::WORD_W-1:0] m_store      [2][8][8];
  int                         m_cwp        [2];
  int                         m_cansave    [2];
  int                         m_canrestore [2];

  // what the DUT should show at the next falling edge
  logic                       exp_rd_valid;
  logic [irf_pkg::WORD_W-1:0] exp_rd_data;
  irf_pkg::irf_trap_t         exp_trap;

  int          errors;
  int          checks;
  logic [31:0] rng;
  string       test_name;

  irf_clk_gen irf_clk_gen_i (.clk(clk));

  irf_top irf_top_i (
    .clk       (clk),
    .reset_l   (reset_l),
    .req       (req),
    .rd_en     (rd_en),
    .rd_thread (rd_thread),
    .rd_idx    (rd_idx),
    .rd        (rd),
    .trap      (trap)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    hi = rand32();
    return {hi, rand32()};
  endfunction

  // even parity of each byte computed bit by bit with check bits above the data
  function automatic logic [irf_pkg::WORD_W-1:0] encode(input logic [63:0] d);
    logic [7:0] p;
    p = '0;
    for (int i = 0; i < 8; i++) begin
      for (int b = 0; b < 8; b++) begin
        p[i] = p[i] ^ d[i*8 + b];
      end
    end
    return {p, d};
  endfunction

  // wait for one falling edge within four clock changes
  task automatic wait_fall();
    int edges;
    edges = 0;
    do begin
      @(clk);
      edges++;
    end while (clk !== 1'b0 && edges < 4);
    if (clk !== 1'b0) begin
      $display("timeout, the clock stopped toggling");
      $display("Something failed");
      $finish;
    end
  endtask

  // reset low for four rising edges and released on a falling edge
  task automatic reset_dut();
    int rises;
    int edges;
    rises = 0;
    edges = 0;
    reset_l = 1'b0;
    while (rises < 4 && edges < 20) begin
      @(clk);
      edges++;
      if (clk === 1'b1) begin
        rises++;
      end
    end
    if (rises < 4) begin
      $display("timeout, reset never saw four rising clock edges");
      $display("Something failed");
      $finish;
    end
    wait_fall();
    reset_l = 1'b1;
    for (int t = 0; t < 2; t++) begin
      for (int i = 0; i < 8; i++) begin
        m_regs[t][i] = '0;
      end
      m_cwp[t]        = 0;
      m_cansave[t]    = 7;
      m_canrestore[t] = 0;
    end
    exp_rd_valid = 1'b0;
    exp_rd_data  = '0;
    exp_trap     = '0;
  endtask

  // outputs of the previous cycle's request against the model
  task automatic check_outputs();
    checks++;
    if (rd.valid !== exp_rd_valid) begin
      errors++;
      $display("CHECK FAILED %s rd.valid expected %0b actual %0b",
               test_name, exp_rd_valid, rd.valid);
    end
    if (exp_rd_valid && rd.data !== exp_rd_data) begin
      errors++;
      $display("CHECK FAILED %s rd.data expected %h actual %h",
               test_name, exp_rd_data, rd.data);
    end
    if (trap.valid !== exp_trap.valid) begin
      errors++;
      $display("CHECK FAILED %s trap.valid expected %0b actual %0b",
               test_name, exp_trap.valid, trap.valid);
    end
    // kind and thread only mean something while the trap is valid
    if (exp_trap.valid && trap.kind !== exp_trap.kind) begin
      errors++;
      $display("CHECK FAILED %s trap.kind expected %0b actual %0b",
               test_name, exp_trap.kind, trap.kind);
    end
    if (exp_trap.valid && trap.thread !== exp_trap.thread) begin
      errors++;
      $display("CHECK FAILED %s trap.thread expected %0b actual %0b",
               test_name, exp_trap.thread, trap.thread);
    end
  endtask

  // one clock of stimulus with the model updated as the DUT will be
  task automatic cycle(input irf_pkg::irf_op_e op, input logic thr,
                       input logic [2:0] idx, input logic [63:0] data,
                       input logic ren, input logic rthr, input logic [2:0] ridx);
    wait_fall();
    check_outputs();
    // the read sees the register before this cycle's update
    exp_rd_valid = ren;
    if (ren) begin
      exp_rd_data = m_regs[rthr][ridx];
    end
    exp_trap = '0;
    if (op == irf_pkg::OP_WRITE) begin
      m_regs[thr][idx] = encode(data);
    end else if (op == irf_pkg::OP_SAVE && m_cansave[thr] != 0) begin
      for (int r = 0; r < 8; r++) begin
        m_store[thr][m_cwp[thr]][r] = m_regs[thr][r];
      end
      m_cwp[thr] = (m_cwp[thr] + 1) % 8;
      m_cansave[thr]--;
      m_canrestore[thr]++;
    end else if (op == irf_pkg::OP_RESTORE && m_canrestore[thr] != 0) begin
      m_cwp[thr] = (m_cwp[thr] + 7) % 8;
      for (int r = 0; r < 8; r++) begin
        m_regs[thr][r] = m_store[thr][m_cwp[thr]][r];
      end
      m_cansave[thr]++;
      m_canrestore[thr]--;
    end else if (op == irf_pkg::OP_SAVE || op == irf_pkg::OP_RESTORE) begin
      // refused request traps one cycle later and nothing else moves
      exp_trap.valid  = 1'b1;
      exp_trap.kind   = (op == irf_pkg::OP_SAVE) ? irf_pkg::TRAP_OVERFLOW
                                                 : irf_pkg::TRAP_UNDERFLOW;
      exp_trap.thread = thr;
    end
    req.op      = op;
    req.thread  = thr;
    req.reg_idx = idx;
    req.wr_data = data;
    rd_en       = ren;
    rd_thread   = rthr;
    rd_idx      = ridx;
  endtask

  initial begin
    logic [31:0]      r;
    logic [31:0]      s;
    int               sel;
    irf_pkg::irf_op_e op;
    errors    = 0;
    checks    = 0;
    rng       = 32'h4584;
    test_name = "reset";
    req       = '0;
    rd_en     = 1'b0;
    rd_thread = 1'b0;
    rd_idx    = '0;
    reset_l   = 1'b0;
    reset_dut();

    // every register of both threads reads zero with zero parity
    test_name = "reset_zero";
    for (int t = 0; t < 2; t++) begin
      for (int i = 0; i < 8; i++) begin
        cycle(irf_pkg::OP_NOP, 1'b0, 3'd0, 64'd0, 1'b1, 1'(t), 3'(i));
      end
    end

    // same-cycle read gives the old value and the next one the new word
    test_name = "write_parity";
    for (int t = 0; t < 2; t++) begin
      for (int i = 0; i < 8; i++) begin
        cycle(irf_pkg::OP_WRITE, 1'(t), 3'(i), rand64(), 1'b1, 1'(t), 3'(i));
        cycle(irf_pkg::OP_NOP, 1'b0, 3'd0, 64'd0, 1'b1, 1'(t), 3'(i));
      end
    end

    // three nested windows per thread with the threads interleaved
    test_name = "window_nest";
    for (int lvl = 0; lvl < 4; lvl++) begin
      for (int t = 0; t < 2; t++) begin
        for (int i = 0; i < 8; i++) begin
          cycle(irf_pkg::OP_WRITE, 1'(t), 3'(i), rand64(), 1'b0, 1'b0, 3'd0);
        end
        // last pass only overwrites the live window
        if (lvl < 3) begin
          cycle(irf_pkg::OP_SAVE, 1'(t), 3'd0, 64'd0, 1'b0, 1'b0, 3'd0);
        end
      end
    end
    for (int lvl = 0; lvl < 3; lvl++) begin
      for (int t = 0; t < 2; t++) begin
        cycle(irf_pkg::OP_RESTORE, 1'(t), 3'd0, 64'd0, 1'b1, 1'(t), 3'd0);
        for (int i = 0; i < 8; i++) begin
          cycle(irf_pkg::OP_NOP, 1'b0, 3'd0, 64'd0, 1'b1, 1'(t), 3'(i));
        end
      end
    end

    // a write before each save gives every slot its own contents
    // seven saves fit and the eighth traps while thread 1 is read
    test_name = "overflow";
    for (int n = 0; n < 8; n++) begin
      cycle(irf_pkg::OP_WRITE, 1'b0, 3'(n), rand64(), 1'b1, 1'b1, 3'(n));
      cycle(irf_pkg::OP_SAVE, 1'b0, 3'd0, 64'd0, 1'b1, 1'b0, 3'(n));
    end
    test_name = "underflow";
    for (int n = 0; n < 8; n++) begin
      cycle(irf_pkg::OP_RESTORE, 1'b0, 3'd0, 64'd0, 1'b1, 1'b0, 3'(n));
    end

    // mix of 50% writes, 15% saves, 15% restores, 20% idle
    test_name = "random";
    for (int n = 0; n < 3000; n++) begin
      r   = rand32();
      s   = rand32();
      sel = int'(r % 32'd100);
      if (sel < 50) begin
        op = irf_pkg::OP_WRITE;
      end else if (sel < 65) begin
        op = irf_pkg::OP_SAVE;
      end else if (sel < 80) begin
        op = irf_pkg::OP_RESTORE;
      end else begin
        op = irf_pkg::OP_NOP;
      end
      cycle(op, r[8], r[11:9], rand64(), s[3:0] != 4'd0, s[4], s[7:5]);
    end

    // let the last request show up and get checked
    test_name = "drain";
    cycle(irf_pkg::OP_NOP, 1'b0, 3'd0, 64'd0, 1'b0, 1'b0, 3'd0);
    cycle(irf_pkg::OP_NOP, 1'b0, 3'd0, 64'd0, 1'b0, 1'b0, 3'd0);

    $display("irf_tb finished with %0d checks and %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- test/irf_clk_gen.sv
// ==========================================================================
// irf testbench clock
// free-running 4 ns clock for the register file testbench
// ==========================================================================

`timescale 1ns/10ps

module irf_clk_gen (
  output logic clk
);

  // half period of 2 ns
  initial begin
    clk = 1'b0;
    forever begin
      #2;
      clk = ~clk;
    end
  end

endmodule

//--- source/irf_top.sv
// ==========================================================================
// irf top
// windowed integer register file, window control beside a write path,
// an eight-cell bank and a registered read path
// ==========================================================================

`timescale 1ns/10ps

module irf_top (
  input  logic                          clk,
  input  logic                          reset_l,
  input  irf_pkg::irf_req_t             req,
  input  logic                          rd_en,
  input  logic                          rd_thread,
  input  logic [irf_pkg::REG_IDX_W-1:0] rd_idx,
  output irf_pkg::irf_rd_t              rd,
  output irf_pkg::irf_trap_t            trap
);

  irf_pkg::irf_win_cmd_t                                    win_cmd;
  logic [irf_pkg::WORD_W-1:0]                               wr_word;
  logic [irf_pkg::NUM_THREADS*irf_pkg::NUM_REGS-1:0]        wr_en;
  logic [irf_pkg::NUM_REGS-1:0][irf_pkg::WORD_W-1:0]        cell_data;

  // save/restore strobes and traps
  irf_window_ctl irf_window_ctl_i (
    .clk     (clk),
    .reset_l (reset_l),
    .req     (req),
    .win_cmd (win_cmd),
    .trap    (trap)
  );

  // parity encode and write enables
  irf_wr_path irf_wr_path_i (
    .req     (req),
    .wr_word (wr_word),
    .wr_en   (wr_en)
  );

  irf_bank irf_bank_i (
    .clk       (clk),
    .reset_l   (reset_l),
    .wr_en     (wr_en),
    .wr_word   (wr_word),
    .win_cmd   (win_cmd),
    .rd_thread (rd_thread),
    .cell_data (cell_data)
  );

  // one-cycle read latency
  irf_rd_path irf_rd_path_i (
    .clk       (clk),
    .reset_l   (reset_l),
    .rd_en     (rd_en),
    .rd_idx    (rd_idx),
    .cell_data (cell_data),
    .rd        (rd)
  );

endmodule

//--- source/irf_rd_path.sv
// ==========================================================================
// irf read path
// selects one of the eight cell words and registers it with a valid
// ==========================================================================

`timescale 1ns/10ps

module irf_rd_path (
  input  logic                                                 clk,
  input  logic                                                 reset_l,
  input  logic                                                 rd_en,
  input  logic [irf_pkg::REG_IDX_W-1:0]                        rd_idx,
  input  logic [irf_pkg::NUM_REGS-1:0][irf_pkg::WORD_W-1:0]    cell_data,
  output irf_pkg::irf_rd_t                                     rd
);

  logic                       rd_valid_q;
  logic [irf_pkg::WORD_W-1:0] rd_data_q;

  // valid follows rd_en by one cycle
  always_ff @(posedge clk) begin
    if (!reset_l) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_en;
    end
  end

  // cell words already reflect rd_thread, pre-update value is captured
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data_q <= cell_data[rd_idx];
    end
  end

  assign rd.valid = rd_valid_q;
  assign rd.data  = rd_data_q;

endmodule

//--- source/irf_bank.sv
// ==========================================================================
// irf register bank
// eight register cells sharing write word, window command and read
// thread, each with its own pair of per-thread write enables
// ==========================================================================

`timescale 1ns/10ps

module irf_bank (
  input  logic                                                 clk,
  input  logic                                                 reset_l,
  input  logic [irf_pkg::NUM_THREADS*irf_pkg::NUM_REGS-1:0]    wr_en,
  input  logic [irf_pkg::WORD_W-1:0]                           wr_word,
  input  irf_pkg::irf_win_cmd_t                                win_cmd,
  input  logic                                                 rd_thread,
  output logic [irf_pkg::NUM_REGS-1:0][irf_pkg::WORD_W-1:0]    cell_data
);

  for (genvar r = 0; r < irf_pkg::NUM_REGS; r++) begin : g_cell
    logic [irf_pkg::NUM_THREADS-1:0] cell_wr_en;

    // pick this register's enable out of each thread's group of eight
    for (genvar t = 0; t < irf_pkg::NUM_THREADS; t++) begin : g_en
      assign cell_wr_en[t] = wr_en[t*irf_pkg::NUM_REGS + r];
    end

    // every cell sees the same save/restore strobe and slot
    irf_cell irf_cell_i (
      .clk       (clk),
      .reset_l   (reset_l),
      .wr_en     (cell_wr_en),
      .wr_word   (wr_word),
      .win_cmd   (win_cmd),
      .rd_thread (rd_thread),
      .rd_data   (cell_data[r])
    );
  end

endmodule

//--- source/irf_cell.sv
// ==========================================================================
// irf register cell
// one 72-bit register per thread plus a 16-entry window store, saves
// copy the register out and restores load it back in a single clock
// ==========================================================================

`timescale 1ns/10ps

module irf_cell (
  input  logic                               clk,
  input  logic                               reset_l,
  input  logic [irf_pkg::NUM_THREADS-1:0]    wr_en,
  input  logic [irf_pkg::WORD_W-1:0]         wr_word,
  input  irf_pkg::irf_win_cmd_t              win_cmd,
  input  logic                               rd_thread,
  output logic [irf_pkg::WORD_W-1:0]         rd_data
);

  // architectural register, one per thread
  logic [irf_pkg::WORD_W-1:0] regs  [irf_pkg::NUM_THREADS];
  // window store, slot msb selects the thread half
  logic [irf_pkg::WORD_W-1:0] store [irf_pkg::NUM_THREADS*irf_pkg::NUM_WINDOWS];

  logic                       slot_thread;
  logic [irf_pkg::NUM_THREADS-1:0] restore_en;

  assign slot_thread = win_cmd.slot[irf_pkg::SLOT_W-1];

  // restore hits only the thread named by the slot
  always_comb begin
    restore_en = '0;
    restore_en[slot_thread] = win_cmd.restore;
  end

  always_ff @(posedge clk) begin
    if (!reset_l) begin
      for (int t = 0; t < irf_pkg::NUM_THREADS; t++) begin
        regs[t] <= '0;
      end
    end else begin
      for (int t = 0; t < irf_pkg::NUM_THREADS; t++) begin
        // restore wins over a write to the same thread
        if (restore_en[t]) begin
          regs[t] <= store[win_cmd.slot];
        end else if (wr_en[t]) begin
          regs[t] <= wr_word;
        end
      end
    end
  end

  // save takes the value from before this edge, register is kept
  always_ff @(posedge clk) begin
    if (win_cmd.save) begin
      store[win_cmd.slot] <= regs[slot_thread];
    end
  end

  assign rd_data = regs[rd_thread];

  // one op per cycle upstream, so a restore never meets a write
  a_no_wr_on_restore: assert property (@(posedge clk) disable iff (!reset_l)
    !(win_cmd.restore && wr_en[slot_thread]))
    else $error("restore and write to thread %0d in one cycle", slot_thread);

endmodule

//--- source/irf_wr_path.sv
// ==========================================================================
// irf write path
// adds even byte parity above the write data and decodes the one-hot
// write enable over thread and register index
// ==========================================================================

`timescale 1ns/10ps

module irf_wr_path (
  input  irf_pkg::irf_req_t                                     req,
  output logic [irf_pkg::WORD_W-1:0]                            wr_word,
  output logic [irf_pkg::NUM_THREADS*irf_pkg::NUM_REGS-1:0]     wr_en
);

  logic [irf_pkg::PAR_W-1:0] par;

  // check bit i covers data byte i
  always_comb begin
    for (int i = 0; i < irf_pkg::PAR_W; i++) begin
      par[i] = ^req.wr_data[i*8 +: 8];
    end
  end

  // parity bits land in word bits 64 and up
  assign wr_word = {par, req.wr_data};

  // enable index is thread*8 + reg_idx, only for plain writes
  always_comb begin
    wr_en = '0;
    if (req.op == irf_pkg::OP_WRITE) begin
      wr_en[{req.thread, req.reg_idx}] = 1'b1;
    end
  end

endmodule

//--- source/irf_window_ctl.sv
// ==========================================================================
// irf window controller
// tracks cwp, cansave and canrestore per thread, turns save/restore
// requests into strobes for the bank and registers a trap when refused
// ==========================================================================

`timescale 1ns/10ps

module irf_window_ctl (
  input  logic                  clk,
  input  logic                  reset_l,
  input  irf_pkg::irf_req_t     req,
  output irf_pkg::irf_win_cmd_t win_cmd,
  output irf_pkg::irf_trap_t    trap
);

  // per-thread window state
  logic [irf_pkg::CWP_W-1:0] cwp        [irf_pkg::NUM_THREADS];
  logic [irf_pkg::CWP_W-1:0] cansave    [irf_pkg::NUM_THREADS];
  logic [irf_pkg::CWP_W-1:0] canrestore [irf_pkg::NUM_THREADS];

  logic                      is_save;
  logic                      is_restore;
  logic                      save_ok;
  logic                      restore_ok;
  logic [irf_pkg::CWP_W-1:0] cur_cwp;
  logic [irf_pkg::CWP_W-1:0] slot_cwp;
  irf_pkg::irf_trap_t        trap_d;

  // decode of the request against the current counts
  always_comb begin
    cur_cwp    = cwp[req.thread];
    is_save    = (req.op == irf_pkg::OP_SAVE);
    is_restore = (req.op == irf_pkg::OP_RESTORE);
    save_ok    = is_save && (cansave[req.thread] != '0);
    restore_ok = is_restore && (canrestore[req.thread] != '0);
    // restore reads back the window below cwp, wraps mod 8
    slot_cwp   = restore_ok ? cur_cwp - 1'b1 : cur_cwp;
  end

  // strobes go out in the request cycle
  assign win_cmd.save    = save_ok;
  assign win_cmd.restore = restore_ok;
  assign win_cmd.slot    = {req.thread, slot_cwp};

  always_ff @(posedge clk) begin
    if (!reset_l) begin
      for (int t = 0; t < irf_pkg::NUM_THREADS; t++) begin
        cwp[t]        <= '0;
        cansave[t]    <= irf_pkg::CWP_W'(irf_pkg::NUM_WINDOWS - 1);
        canrestore[t] <= '0;
      end
    end else if (save_ok) begin
      cwp[req.thread]        <= cur_cwp + 1'b1;
      cansave[req.thread]    <= cansave[req.thread] - 1'b1;
      canrestore[req.thread] <= canrestore[req.thread] + 1'b1;
    end else if (restore_ok) begin
      cwp[req.thread]        <= cur_cwp - 1'b1;
      cansave[req.thread]    <= cansave[req.thread] + 1'b1;
      canrestore[req.thread] <= canrestore[req.thread] - 1'b1;
    end
  end

  // refused request, trap shows up one cycle later for one cycle
  always_comb begin
    trap_d.valid  = (is_save && !save_ok) || (is_restore && !restore_ok);
    trap_d.kind   = is_restore ? irf_pkg::TRAP_UNDERFLOW : irf_pkg::TRAP_OVERFLOW;
    trap_d.thread = req.thread;
  end

  always_ff @(posedge clk) begin
    if (!reset_l) begin
      trap <= '0;
    end else begin
      trap <= trap_d;
    end
  end

  // counts move in pairs, so their sum stays at windows minus one
  for (genvar t = 0; t < irf_pkg::NUM_THREADS; t++) begin : g_cnt_chk
    a_cnt_sum: assert property (@(posedge clk) disable iff (!reset_l)
      ({1'b0, cansave[t]} + {1'b0, canrestore[t]}) ==
        (irf_pkg::CWP_W + 1)'(irf_pkg::NUM_WINDOWS - 1))
      else $error("window counts out of balance on thread %0d", t);
  end

  // the bank would both store and load a slot otherwise
  a_one_cmd: assert property (@(posedge clk) disable iff (!reset_l)
    !(win_cmd.save && win_cmd.restore))
    else $error("save and restore strobed together");

endmodule

//--- source/irf_pkg.sv
// ==========================================================================
// irf package
// shared widths, opcodes, trap kinds and bus structs for the windowed
// integer register file of the two-thread core
// ==========================================================================

package irf_pkg;

  // geometry
  localparam int NUM_THREADS = 2;
  localparam int NUM_REGS    = 8;
  localparam int NUM_WINDOWS = 8;

  // word layout, parity bits sit above the data
  localparam int DATA_W = 64;
  localparam int PAR_W  = 8;
  localparam int WORD_W = DATA_W + PAR_W;

  // index widths
  localparam int REG_IDX_W = 3;
  localparam int CWP_W     = 3;
  // window store address, thread in the msb
  localparam int SLOT_W    = 4;

  // request opcodes
  typedef enum logic [1:0] {
    OP_NOP     = 2'd0,
    OP_WRITE   = 2'd1,
    OP_SAVE    = 2'd2,
    OP_RESTORE = 2'd3
  } irf_op_e;

  // refused save gives overflow, refused restore gives underflow
  typedef enum logic {
    TRAP_OVERFLOW  = 1'b0,
    TRAP_UNDERFLOW = 1'b1
  } irf_trap_e;

  // one request per cycle, valid when op is not nop
  typedef struct packed {
    irf_op_e               op;
    logic                  thread;
    logic [REG_IDX_W-1:0]  reg_idx;
    logic [DATA_W-1:0]     wr_data;
  } irf_req_t;

  // parallel save/restore strobe to every cell
  typedef struct packed {
    logic              save;
    logic              restore;
    logic [SLOT_W-1:0] slot;
  } irf_win_cmd_t;

  typedef struct packed {
    logic      valid;
    irf_trap_e kind;
    logic      thread;
  } irf_trap_t;

  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] data;
  } irf_rd_t;

endpackage
